//--- hdl/id_ctrl_decode.sv
// Control decoder: format class, register indices, enables and memory action
// of the held instruction. Purely combinational.
`timescale 1ns/1ns
`include "id_defs.svh"

module id_ctrl_decode (
  input  logic [31:0]               i_inst,
  output id_pkg::opcode_e           o_opcode,
  output logic [2:0]                o_funct3,
  output logic [6:0]                o_funct7,
  output id_pkg::itype_e            o_itype,
  output logic [`REG_IDX_W-1:0]     o_rs1,
  output logic [`REG_IDX_W-1:0]     o_rs2,
  output logic [`REG_IDX_W-1:0]     o_rd,
  output logic                      o_rs1_ren,
  output logic                      o_rs2_ren,
  output logic                      o_rd_wen,
  output id_pkg::mem_action_e       o_mem_action
);

  import id_pkg::*;

  assign o_opcode = opcode_e'(i_inst[6:0]);
  assign o_funct3 = i_inst[14:12];
  assign o_funct7 = i_inst[31:25];

  // Format class and memory action of each major opcode
  always_comb begin
    o_itype      = ITYPE_NONE;
    o_mem_action = MEM_NONE;
    case (i_inst[6:0])
      OPC_OP, OPC_OP_32:                   o_itype = ITYPE_R;
      OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR: o_itype = ITYPE_I;
      OPC_LOAD: begin
        o_itype      = ITYPE_I;
        o_mem_action = MEM_LOAD;
      end
      OPC_STORE: begin
        o_itype      = ITYPE_S;
        o_mem_action = MEM_STORE;
      end
      OPC_BRANCH:                          o_itype = ITYPE_B;
      OPC_LUI, OPC_AUIPC:                  o_itype = ITYPE_U;
      OPC_JAL:                             o_itype = ITYPE_J;
      default: ;
    endcase
  end

  // Sources read by each class, and rd written by all but S and B
  always_comb begin
    o_rs1_ren = 1'b0;
    o_rs2_ren = 1'b0;
    o_rd_wen  = 1'b0;
    case (o_itype)
      ITYPE_R: begin
        o_rs1_ren = 1'b1;
        o_rs2_ren = 1'b1;
        o_rd_wen  = 1'b1;
      end
      ITYPE_I: begin
        o_rs1_ren = 1'b1;
        o_rd_wen  = 1'b1;
      end
      ITYPE_S, ITYPE_B: begin
        o_rs1_ren = 1'b1;
        o_rs2_ren = 1'b1;
      end
      ITYPE_U, ITYPE_J: begin
        o_rd_wen = 1'b1;
      end
      default: ;
    endcase
  end

  // An index whose enable is low reads as x0
  assign o_rs1 = o_rs1_ren ? i_inst[19:15] : '0;
  assign o_rs2 = o_rs2_ren ? i_inst[24:20] : '0;
  assign o_rd  = o_rd_wen ? i_inst[11:7] : '0;

endmodule

//--- hdl/id_imm_gen.sv
// Immediate generator: all five RISC-V immediate forms of the held instruction,
// sign extended to the data width whatever the format class is.
`timescale 1ns/1ns
`include "id_defs.svh"

module id_imm_gen (
  input  logic [31:0]       i_inst,
  output logic [`XLEN-1:0]  o_imm_i,
  output logic [`XLEN-1:0]  o_imm_s,
  output logic [`XLEN-1:0]  o_imm_b,
  output logic [`XLEN-1:0]  o_imm_u,
  output logic [`XLEN-1:0]  o_imm_j
);

  // Bit 31 is the sign of every form
  logic sign;

  assign sign = i_inst[31];

  // I form, inst[31:20]
  assign o_imm_i = {{(`XLEN-12){sign}}, i_inst[31:20]};

  // S form, inst[31:25] and inst[11:7]
  assign o_imm_s = {{(`XLEN-12){sign}}, i_inst[31:25], i_inst[11:7]};

  // B form, a multiple of 2
  assign o_imm_b = {{(`XLEN-13){sign}}, i_inst[31], i_inst[7], i_inst[30:25],
                    i_inst[11:8], 1'b0};

  // U form fills the upper 20 bits of the low word
  assign o_imm_u = {{(`XLEN-32){sign}}, i_inst[31:12], 12'b0};

  // J form, a multiple of 2
  assign o_imm_j = {{(`XLEN-21){sign}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

endmodule

//--- hdl/id_operand_mux.sv
// Operand combiner: forms op1, op2, the jump or branch target, the memory address
// and the store data from the class, immediates, register data and pc.
`timescale 1ns/1ns
`include "id_defs.svh"

module id_operand_mux (
  input  id_pkg::opcode_e   i_opcode,
  input  id_pkg::itype_e    i_itype,
  input  logic [`XLEN-1:0]  i_pc,
  input  logic [`XLEN-1:0]  i_imm_i,
  input  logic [`XLEN-1:0]  i_imm_s,
  input  logic [`XLEN-1:0]  i_imm_b,
  input  logic [`XLEN-1:0]  i_imm_u,
  input  logic [`XLEN-1:0]  i_imm_j,
  input  logic [`XLEN-1:0]  i_rs1_data,
  input  logic [`XLEN-1:0]  i_rs2_data,
  output logic [`XLEN-1:0]  o_op1,
  output logic [`XLEN-1:0]  o_op2,
  output logic [`XLEN-1:0]  o_t1,
  output logic [`XLEN-1:0]  o_memaddr,
  output logic [`XLEN-1:0]  o_memwdata
);

  import id_pkg::*;

  logic [`XLEN-1:0] jalr_sum;

  assign jalr_sum = i_rs1_data + i_imm_i;

  always_comb begin
    o_op1      = '0;
    o_op2      = '0;
    o_t1       = '0;
    o_memaddr  = '0;
    o_memwdata = '0;
    case (i_itype)
      ITYPE_R: begin
        o_op1 = i_rs1_data;
        o_op2 = i_rs2_data;
      end
      ITYPE_B: begin
        o_op1 = i_rs1_data;
        o_op2 = i_rs2_data;
        o_t1  = i_pc + i_imm_b;
      end
      ITYPE_I, ITYPE_S, ITYPE_U, ITYPE_J: begin
        // These classes share a format but differ by opcode
        case (i_opcode)
          OPC_OP_IMM, OPC_OP_IMM_32: begin
            o_op1 = i_rs1_data;
            o_op2 = i_imm_i;
          end
          OPC_LOAD: begin
            o_op1     = i_rs1_data;
            o_op2     = i_imm_i;
            o_memaddr = i_rs1_data + i_imm_i;
          end
          OPC_STORE: begin
            o_memaddr  = i_rs1_data + i_imm_s;
            o_memwdata = i_rs2_data;
          end
          OPC_JAL: begin
            o_op1 = i_pc;
            o_op2 = `XLEN'd4;
            o_t1  = i_pc + i_imm_j;
          end
          OPC_JALR: begin
            o_op1 = i_pc;
            o_op2 = `XLEN'd4;
            o_t1  = {jalr_sum[`XLEN-1:1], 1'b0};
          end
          OPC_LUI: begin
            o_op2 = i_imm_u;
          end
          OPC_AUIPC: begin
            o_op1 = i_pc;
            o_op2 = i_imm_u;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/id_pkg.sv
// Enumerated types of the decode stage, imported by the RTL and the testbench.
package id_pkg;

  // RV64I major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111
  } opcode_e;

  // Instruction format class
  // Unsupported opcodes report ITYPE_NONE
  typedef enum logic [2:0] {
    ITYPE_NONE = 3'd0,
    ITYPE_R    = 3'd1,
    ITYPE_I    = 3'd2,
    ITYPE_S    = 3'd3,
    ITYPE_B    = 3'd4,
    ITYPE_U    = 3'd5,
    ITYPE_J    = 3'd6
  } itype_e;

  // Memory access requested by the instruction
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_action_e;

endpackage

//--- hdl/id_regfile.sv
// Integer register file with two combinational read ports and one write-back port.
// x0 reads as zero and ignores writes.
`timescale 1ns/1ns
`include "id_defs.svh"

module id_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_wb_wen,
  input  logic [`REG_IDX_W-1:0] i_wb_rd,
  input  logic [`XLEN-1:0]      i_wb_data,
  input  logic [`REG_IDX_W-1:0] i_rs1,
  input  logic [`REG_IDX_W-1:0] i_rs2,
  output logic [`XLEN-1:0]      o_rs1_data,
  output logic [`XLEN-1:0]      o_rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // The whole array is cleared on reset so that every read is defined
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_wen && (i_wb_rd != '0)) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  // No bypass, a write on an edge becomes visible after that edge
  always_comb begin
    if (i_rs1 == '0) begin
      o_rs1_data = '0;
    end else begin
      o_rs1_data = regs[i_rs1];
    end
  end

  always_comb begin
    if (i_rs2 == '0) begin
      o_rs2_data = '0;
    end else begin
      o_rs2_data = regs[i_rs2];
    end
  end

endmodule

//--- hdl/id_stage.sv
// Decode stage register: holds one fetched item under the req/ack pairs and
// drives every decode result out as zero while the stage is empty.
`timescale 1ns/1ns
`include "id_defs.svh"

module id_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_fetched_req,
  output logic                  o_fetched_ack,
  input  logic                  i_decoded_ack,
  output logic                  o_decoded_req,
  input  logic [`XLEN-1:0]      i_pc,
  input  logic [`XLEN-1:0]      i_pc_pred,
  input  logic [31:0]           i_inst,
  output logic [31:0]           o_hold_inst,
  output logic [`XLEN-1:0]      o_hold_pc,
  output logic [`XLEN-1:0]      o_pc,
  output logic [`XLEN-1:0]      o_pc_pred,
  output logic [31:0]           o_inst,
  input  id_pkg::opcode_e       i_opcode,
  input  logic [2:0]            i_funct3,
  input  logic [6:0]            i_funct7,
  input  id_pkg::itype_e        i_itype,
  input  logic [`REG_IDX_W-1:0] i_rs1,
  input  logic [`REG_IDX_W-1:0] i_rs2,
  input  logic [`REG_IDX_W-1:0] i_rd,
  input  logic                  i_rs1_ren,
  input  logic                  i_rs2_ren,
  input  logic                  i_rd_wen,
  input  id_pkg::mem_action_e   i_mem_action,
  input  logic [`XLEN-1:0]      i_op1,
  input  logic [`XLEN-1:0]      i_op2,
  input  logic [`XLEN-1:0]      i_t1,
  input  logic [`XLEN-1:0]      i_memaddr,
  input  logic [`XLEN-1:0]      i_memwdata,
  output id_pkg::opcode_e       o_opcode,
  output logic [2:0]            o_funct3,
  output logic [6:0]            o_funct7,
  output id_pkg::itype_e        o_itype,
  output logic [`REG_IDX_W-1:0] o_rs1,
  output logic [`REG_IDX_W-1:0] o_rs2,
  output logic [`REG_IDX_W-1:0] o_rd,
  output logic                  o_rs1_ren,
  output logic                  o_rs2_ren,
  output logic                  o_rd_wen,
  output id_pkg::mem_action_e   o_mem_action,
  output logic [`XLEN-1:0]      o_op1,
  output logic [`XLEN-1:0]      o_op2,
  output logic [`XLEN-1:0]      o_t1,
  output logic [`XLEN-1:0]      o_memaddr,
  output logic [`XLEN-1:0]      o_memwdata
);

  import id_pkg::*;

  logic              valid_q;
  logic              fetched_hs;
  logic [`XLEN-1:0]  pc_q;
  logic [`XLEN-1:0]  pc_pred_q;
  logic [31:0]       inst_q;

  // ****************************************************************************
  // Handshake and holding register
  // ****************************************************************************

  // Accept when empty, or when the held item leaves on this same edge
  assign o_fetched_ack = !valid_q || i_decoded_ack;
  assign fetched_hs    = i_fetched_req && o_fetched_ack;
  assign o_decoded_req = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (fetched_hs) begin
      valid_q <= 1'b1;
    end else if (i_decoded_ack) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetched_hs) begin
      pc_q      <= i_pc;
      pc_pred_q <= i_pc_pred;
      inst_q    <= i_inst;
    end
  end

  assign o_hold_inst = inst_q;
  assign o_hold_pc   = pc_q;

  // ****************************************************************************
  // Outputs forced to zero while empty
  // ****************************************************************************

  assign o_pc         = valid_q ? pc_q : '0;
  assign o_pc_pred    = valid_q ? pc_pred_q : '0;
  assign o_inst       = valid_q ? inst_q : '0;
  assign o_opcode     = valid_q ? i_opcode : opcode_e'(7'd0);
  assign o_funct3     = valid_q ? i_funct3 : '0;
  assign o_funct7     = valid_q ? i_funct7 : '0;
  assign o_itype      = valid_q ? i_itype : ITYPE_NONE;
  assign o_rs1        = valid_q ? i_rs1 : '0;
  assign o_rs2        = valid_q ? i_rs2 : '0;
  assign o_rd         = valid_q ? i_rd : '0;
  assign o_rs1_ren    = valid_q && i_rs1_ren;
  assign o_rs2_ren    = valid_q && i_rs2_ren;
  assign o_rd_wen     = valid_q && i_rd_wen;
  assign o_mem_action = valid_q ? i_mem_action : MEM_NONE;
  assign o_op1        = valid_q ? i_op1 : '0;
  assign o_op2        = valid_q ? i_op2 : '0;
  assign o_t1         = valid_q ? i_t1 : '0;
  assign o_memaddr    = valid_q ? i_memaddr : '0;
  assign o_memwdata   = valid_q ? i_memwdata : '0;

endmodule

//--- hdl/id_top.sv
// Top of the instruction decode stage: stage register, decoders, operand
// combiner and register file, joined by wires only.
`timescale 1ns/1ns
`include "id_defs.svh"

module id_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_fetched_req,
  output logic                  o_fetched_ack,
  input  logic                  i_decoded_ack,
  output logic                  o_decoded_req,
  input  logic [`XLEN-1:0]      i_pc,
  input  logic [`XLEN-1:0]      i_pc_pred,
  input  logic [31:0]           i_inst,
  input  logic                  i_wb_wen,
  input  logic [`REG_IDX_W-1:0] i_wb_rd,
  input  logic [`XLEN-1:0]      i_wb_data,
  output logic [`XLEN-1:0]      o_pc,
  output logic [`XLEN-1:0]      o_pc_pred,
  output logic [31:0]           o_inst,
  output id_pkg::opcode_e       o_opcode,
  output logic [2:0]            o_funct3,
  output logic [6:0]            o_funct7,
  output id_pkg::itype_e        o_itype,
  output logic [`REG_IDX_W-1:0] o_rs1,
  output logic [`REG_IDX_W-1:0] o_rs2,
  output logic [`REG_IDX_W-1:0] o_rd,
  output logic                  o_rs1_ren,
  output logic                  o_rs2_ren,
  output logic                  o_rd_wen,
  output id_pkg::mem_action_e   o_mem_action,
  output logic [`XLEN-1:0]      o_op1,
  output logic [`XLEN-1:0]      o_op2,
  output logic [`XLEN-1:0]      o_t1,
  output logic [`XLEN-1:0]      o_memaddr,
  output logic [`XLEN-1:0]      o_memwdata
);

  import id_pkg::*;

  logic [31:0]            hold_inst;
  logic [`XLEN-1:0]       hold_pc;
  opcode_e                dec_opcode;
  logic [2:0]             dec_funct3;
  logic [6:0]             dec_funct7;
  itype_e                 dec_itype;
  logic [`REG_IDX_W-1:0]  dec_rs1;
  logic [`REG_IDX_W-1:0]  dec_rs2;
  logic [`REG_IDX_W-1:0]  dec_rd;
  logic                   dec_rs1_ren;
  logic                   dec_rs2_ren;
  logic                   dec_rd_wen;
  mem_action_e            dec_mem_action;
  logic [`XLEN-1:0]       imm_i;
  logic [`XLEN-1:0]       imm_s;
  logic [`XLEN-1:0]       imm_b;
  logic [`XLEN-1:0]       imm_u;
  logic [`XLEN-1:0]       imm_j;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`XLEN-1:0]       mux_op1;
  logic [`XLEN-1:0]       mux_op2;
  logic [`XLEN-1:0]       mux_t1;
  logic [`XLEN-1:0]       mux_memaddr;
  logic [`XLEN-1:0]       mux_memwdata;

  id_stage stage_i (
    .clk            (clk),
    .rst            (rst),
    .i_fetched_req  (i_fetched_req),
    .o_fetched_ack  (o_fetched_ack),
    .i_decoded_ack  (i_decoded_ack),
    .o_decoded_req  (o_decoded_req),
    .i_pc           (i_pc),
    .i_pc_pred      (i_pc_pred),
    .i_inst         (i_inst),
    .o_hold_inst    (hold_inst),
    .o_hold_pc      (hold_pc),
    .o_pc           (o_pc),
    .o_pc_pred      (o_pc_pred),
    .o_inst         (o_inst),
    .i_opcode       (dec_opcode),
    .i_funct3       (dec_funct3),
    .i_funct7       (dec_funct7),
    .i_itype        (dec_itype),
    .i_rs1          (dec_rs1),
    .i_rs2          (dec_rs2),
    .i_rd           (dec_rd),
    .i_rs1_ren      (dec_rs1_ren),
    .i_rs2_ren      (dec_rs2_ren),
    .i_rd_wen       (dec_rd_wen),
    .i_mem_action   (dec_mem_action),
    .i_op1          (mux_op1),
    .i_op2          (mux_op2),
    .i_t1           (mux_t1),
    .i_memaddr      (mux_memaddr),
    .i_memwdata     (mux_memwdata),
    .o_opcode       (o_opcode),
    .o_funct3       (o_funct3),
    .o_funct7       (o_funct7),
    .o_itype        (o_itype),
    .o_rs1          (o_rs1),
    .o_rs2          (o_rs2),
    .o_rd           (o_rd),
    .o_rs1_ren      (o_rs1_ren),
    .o_rs2_ren      (o_rs2_ren),
    .o_rd_wen       (o_rd_wen),
    .o_mem_action   (o_mem_action),
    .o_op1          (o_op1),
    .o_op2          (o_op2),
    .o_t1           (o_t1),
    .o_memaddr      (o_memaddr),
    .o_memwdata     (o_memwdata)
  );

  id_ctrl_decode ctrl_decode_i (
    .i_inst       (hold_inst),
    .o_opcode     (dec_opcode),
    .o_funct3     (dec_funct3),
    .o_funct7     (dec_funct7),
    .o_itype      (dec_itype),
    .o_rs1        (dec_rs1),
    .o_rs2        (dec_rs2),
    .o_rd         (dec_rd),
    .o_rs1_ren    (dec_rs1_ren),
    .o_rs2_ren    (dec_rs2_ren),
    .o_rd_wen     (dec_rd_wen),
    .o_mem_action (dec_mem_action)
  );

  id_imm_gen imm_gen_i (
    .i_inst  (hold_inst),
    .o_imm_i (imm_i),
    .o_imm_s (imm_s),
    .o_imm_b (imm_b),
    .o_imm_u (imm_u),
    .o_imm_j (imm_j)
  );

  // Index ports are already zero for unused sources, so rs data reads as x0
  id_regfile regfile_i (
    .clk        (clk),
    .rst        (rst),
    .i_wb_wen   (i_wb_wen),
    .i_wb_rd    (i_wb_rd),
    .i_wb_data  (i_wb_data),
    .i_rs1      (dec_rs1),
    .i_rs2      (dec_rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  id_operand_mux operand_mux_i (
    .i_opcode   (dec_opcode),
    .i_itype    (dec_itype),
    .i_pc       (hold_pc),
    .i_imm_i    (imm_i),
    .i_imm_s    (imm_s),
    .i_imm_b    (imm_b),
    .i_imm_u    (imm_u),
    .i_imm_j    (imm_j),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_op1      (mux_op1),
    .o_op2      (mux_op2),
    .o_t1       (mux_t1),
    .o_memaddr  (mux_memaddr),
    .o_memwdata (mux_memwdata)
  );

endmodule

//--- id_top.f
+incdir+include
hdl/id_pkg.sv
hdl/id_regfile.sv
hdl/id_ctrl_decode.sv
hdl/id_imm_gen.sv
hdl/id_operand_mux.sv
hdl/id_stage.sv
hdl/id_top.sv
test/id_tb.sv

//--- include/id_defs.svh
// Width and size macros shared by the decode stage RTL and its testbench.
// Include this file before any module that sizes a port from it.
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// ****************************************************************************
// Data path
// ****************************************************************************

// Data and program counter width of the RV64I core
`define XLEN 64

// ****************************************************************************
// Integer register file
// ****************************************************************************

// Width of an rs1, rs2 or rd index
`define REG_IDX_W 5

// Number of integer registers, x0 included
`define NUM_REGS 32

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f id_top.f --top-module id_tb -o id_sim \
  && ./obj_dir/id_sim > sim.log 2>&1
grep -q "^Everything OK$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- test/id_tb.sv
// Testbench for the decode stage: random RV64I items under random back-pressure,
// each compared with a reference decoder that reads a model register file.
`timescale 1ns/1ns
`include "id_defs.svh"

module id_tb;

  import id_pkg::*;

  // About 400 items at up to 4 cycles each, plus reset, write-back and margin
  localparam int CYCLE_LIMIT = 2000;
  localparam int NUM_ITEMS   = 384;

  logic                  clk;
  logic                  rst;
  logic                  i_fetched_req;
  logic                  o_fetched_ack;
  logic                  i_decoded_ack;
  logic                  o_decoded_req;
  logic [`XLEN-1:0]      i_pc;
  logic [`XLEN-1:0]      i_pc_pred;
  logic [31:0]           i_inst;
  logic                  i_wb_wen;
  logic [`REG_IDX_W-1:0] i_wb_rd;
  logic [`XLEN-1:0]      i_wb_data;
  logic [`XLEN-1:0]      o_pc;
  logic [`XLEN-1:0]      o_pc_pred;
  logic [31:0]           o_inst;
  opcode_e               o_opcode;
  logic [2:0]            o_funct3;
  logic [6:0]            o_funct7;
  itype_e                o_itype;
  logic [`REG_IDX_W-1:0] o_rs1;
  logic [`REG_IDX_W-1:0] o_rs2;
  logic [`REG_IDX_W-1:0] o_rd;
  logic                  o_rs1_ren;
  logic                  o_rs2_ren;
  logic                  o_rd_wen;
  mem_action_e           o_mem_action;
  logic [`XLEN-1:0]      o_op1;
  logic [`XLEN-1:0]      o_op2;
  logic [`XLEN-1:0]      o_t1;
  logic [`XLEN-1:0]      o_memaddr;
  logic [`XLEN-1:0]      o_memwdata;

  integer           seed;
  int               cycle_count = 0;
  string            test_name;
  logic [`XLEN-1:0] model_regs [`NUM_REGS];
  logic [6:0]       supported_opc [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                           OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM,
                                           OPC_OP, OPC_OP_IMM_32, OPC_OP_32};

  // Item currently expected inside the stage
  logic             held_valid;
  logic [31:0]      held_inst;
  logic [`XLEN-1:0] held_pc;
  logic [`XLEN-1:0] held_pc_pred;
  string            held_name;

  // Reference decoder results
  logic                  e_known;
  itype_e                e_itype;
  mem_action_e           e_mem;
  logic                  e_ren1;
  logic                  e_ren2;
  logic                  e_wen;
  logic [`REG_IDX_W-1:0] e_rs1;
  logic [`REG_IDX_W-1:0] e_rs2;
  logic [`REG_IDX_W-1:0] e_rd;
  logic [`XLEN-1:0]      e_op1;
  logic [`XLEN-1:0]      e_op2;
  logic [`XLEN-1:0]      e_t1;
  logic [`XLEN-1:0]      e_addr;
  logic [`XLEN-1:0]      e_wdata;

  logic [31:0]      inst_q [$];
  logic [`XLEN-1:0] pc_q [$];
  string            name_q [$];

  id_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ***************************************************************************
  // Failure reporting and checks
  // ***************************************************************************

  task automatic fail_value(input string field, input logic [63:0] exp,
                            input logic [63:0] act);
    $display("** Error [%s] %s: expected %0h, actual %0h", test_name, field, exp, act);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic fail_other(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check(input string field, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else fail_value(field, exp, act);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      fail_other($sformatf("Timeout, the run did not finish within %0d cycles",
                           CYCLE_LIMIT));
    end
  end

  function automatic bit is_supported(input logic [6:0] opc);
    foreach (supported_opc[k]) begin
      if (supported_opc[k] == opc) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // ***************************************************************************
  // Reference decoder
  // ***************************************************************************

  function automatic void predict(input logic [31:0] inst, input logic [`XLEN-1:0] pc);
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    e_itype = ITYPE_NONE;
    e_mem   = MEM_NONE;
    case (inst[6:0])
      OPC_OP, OPC_OP_32: e_itype = ITYPE_R;
      OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR: e_itype = ITYPE_I;
      OPC_LOAD: begin
        e_itype = ITYPE_I;
        e_mem   = MEM_LOAD;
      end
      OPC_STORE: begin
        e_itype = ITYPE_S;
        e_mem   = MEM_STORE;
      end
      OPC_BRANCH: e_itype = ITYPE_B;
      OPC_LUI, OPC_AUIPC: e_itype = ITYPE_U;
      OPC_JAL: e_itype = ITYPE_J;
      default: e_itype = ITYPE_NONE;
    endcase
    e_known = (e_itype != ITYPE_NONE);
    e_ren1  = e_itype inside {ITYPE_R, ITYPE_I, ITYPE_S, ITYPE_B};
    e_ren2  = e_itype inside {ITYPE_R, ITYPE_S, ITYPE_B};
    e_wen   = e_itype inside {ITYPE_R, ITYPE_I, ITYPE_U, ITYPE_J};
    e_rs1   = e_ren1 ? inst[19:15] : '0;
    e_rs2   = e_ren2 ? inst[24:20] : '0;
    e_rd    = e_wen ? inst[11:7] : '0;
    // x0 of the model is never written, so it reads zero
    a       = model_regs[e_rs1];
    b       = model_regs[e_rs2];
    e_op1   = '0;
    e_op2   = '0;
    e_t1    = '0;
    e_addr  = '0;
    e_wdata = '0;
    case (inst[6:0])
      OPC_OP, OPC_OP_32: begin
        e_op1 = a;
        e_op2 = b;
      end
      OPC_BRANCH: begin
        e_op1 = a;
        e_op2 = b;
        e_t1  = pc + imm_b;
      end
      OPC_OP_IMM, OPC_OP_IMM_32: begin
        e_op1 = a;
        e_op2 = imm_i;
      end
      OPC_LOAD: begin
        e_op1  = a;
        e_op2  = imm_i;
        e_addr = a + imm_i;
      end
      OPC_STORE: begin
        e_addr  = a + imm_s;
        e_wdata = b;
      end
      OPC_JAL: begin
        e_op1 = pc;
        e_op2 = 64'd4;
        e_t1  = pc + imm_j;
      end
      OPC_JALR: begin
        e_op1 = pc;
        e_op2 = 64'd4;
        e_t1  = (a + imm_i) & ~64'd1;
      end
      OPC_LUI: e_op2 = imm_u;
      OPC_AUIPC: begin
        e_op1 = pc;
        e_op2 = imm_u;
      end
      default: ;
    endcase
  endfunction

  // Compares every output with the expected state, empty or holding an item
  task automatic check_outputs();
    logic [31:0]      inst;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_pred;
    inst    = held_valid ? held_inst : 32'h0;
    pc      = held_valid ? held_pc : '0;
    pc_pred = held_valid ? held_pc_pred : '0;
    predict(inst, pc);
    check("o_decoded_req", held_valid, o_decoded_req);
    check("o_fetched_ack", !held_valid || i_decoded_ack, o_fetched_ack);
    check("o_pc", pc, o_pc);
    check("o_pc_pred", pc_pred, o_pc_pred);
    check("o_inst", inst, o_inst);
    if (e_known || !held_valid) begin
      check("o_opcode", inst[6:0], o_opcode);
      check("o_funct3", inst[14:12], o_funct3);
      check("o_funct7", inst[31:25], o_funct7);
    end
    check("o_itype", e_itype, o_itype);
    check("o_mem_action", e_mem, o_mem_action);
    check("o_rs1_ren", e_ren1, o_rs1_ren);
    check("o_rs2_ren", e_ren2, o_rs2_ren);
    check("o_rd_wen", e_wen, o_rd_wen);
    check("o_rs1", e_rs1, o_rs1);
    check("o_rs2", e_rs2, o_rs2);
    check("o_rd", e_rd, o_rd);
    check("o_op1", e_op1, o_op1);
    check("o_op2", e_op2, o_op2);
    check("o_t1", e_t1, o_t1);
    check("o_memaddr", e_addr, o_memaddr);
    check("o_memwdata", e_wdata, o_memwdata);
  endtask

  // ***************************************************************************
  // Stimulus
  // ***************************************************************************

  initial begin
    int               tmp;
    int               next_item;
    int               stall_left;
    logic [6:0]       opc;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] data;
    bit               fetch_xfer;
    bit               dec_xfer;
    seed          = 5;
    rst           = 1'b1;
    i_fetched_req = 1'b0;
    i_decoded_ack = 1'b0;
    i_pc          = '0;
    i_pc_pred     = '0;
    i_inst        = '0;
    i_wb_wen      = 1'b0;
    i_wb_rd       = '0;
    i_wb_data     = '0;
    held_valid    = 1'b0;
    foreach (model_regs[k]) begin
      model_regs[k] = '0;
    end

    test_name = "reset";
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;
    @(negedge clk);
    check_outputs();

    // x1 to x31 first, then an attempt on x0
    test_name = "writeback";
    for (int r = 0; r < `NUM_REGS; r++) begin
      @(posedge clk);
      #10;
      data      = {$random(seed), $random(seed)};
      i_wb_wen  = 1'b1;
      i_wb_rd   = (r + 1) % `NUM_REGS;
      i_wb_data = data;
      if (i_wb_rd != 0) begin
        model_regs[i_wb_rd] = data;
      end
    end
    @(posedge clk);
    #10;
    i_wb_wen = 1'b0;

    // add x1, x0, x0 must see zero operands after the write to x0
    inst_q.push_back(32'h0000_00b3);
    pc_q.push_back(64'h1000);
    name_q.push_back("writeback");
    for (int k = 0; k < NUM_ITEMS; k++) begin
      if (k % 6 == 5) begin
        do begin
          tmp = $random(seed);
          opc = tmp[6:0];
        end while (is_supported(opc));
        name_q.push_back("unsupported");
      end else begin
        tmp = $random(seed);
        opc = supported_opc[$unsigned(tmp) % 11];
        name_q.push_back("decode");
      end
      tmp = $random(seed);
      inst_q.push_back({tmp[31:7], opc});
      pc = {$random(seed), $random(seed)};
      pc[1:0] = 2'b00;
      pc_q.push_back(pc);
    end

    next_item  = 0;
    stall_left = 0;
    while (next_item < inst_q.size() || held_valid) begin
      @(posedge clk);
      #10;
      if (next_item < inst_q.size() && ($random(seed) & 7) != 0) begin
        i_fetched_req = 1'b1;
        i_inst        = inst_q[next_item];
        i_pc          = pc_q[next_item];
        i_pc_pred     = pc_q[next_item] + 64'd4;
      end else begin
        i_fetched_req = 1'b0;
      end
      // Back-pressure spans of two or three cycles
      if (stall_left > 0) begin
        i_decoded_ack = 1'b0;
        stall_left--;
      end else if (($random(seed) & 3) == 0) begin
        i_decoded_ack = 1'b0;
        stall_left    = 1 + ($random(seed) & 1);
      end else begin
        i_decoded_ack = 1'b1;
      end
      @(negedge clk);
      if (!held_valid) begin
        test_name = "idle";
      end else if (!i_decoded_ack) begin
        test_name = "backpressure";
      end else begin
        test_name = held_name;
      end
      check_outputs();
      fetch_xfer = i_fetched_req && (!held_valid || i_decoded_ack);
      dec_xfer   = held_valid && i_decoded_ack;
      if (fetch_xfer) begin
        held_valid   = 1'b1;
        held_inst    = inst_q[next_item];
        held_pc      = pc_q[next_item];
        held_pc_pred = pc_q[next_item] + 64'd4;
        held_name    = name_q[next_item];
        next_item++;
      end else if (dec_xfer) begin
        held_valid = 1'b0;
      end
    end

    test_name = "drain";
    @(posedge clk);
    #10;
    i_fetched_req = 1'b0;
    i_decoded_ack = 1'b0;
    @(negedge clk);
    check_outputs();

    $display("Everything OK");
    $finish;
  end

endmodule
